// File: axil_decerr_rd.sv
module axil_decerr_rd (
    input  logic           aclk,
    input  logic           rst,
    axil_rd_if.subordinate bus
);

    logic ready_q;
    logic rvalid_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            ready_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            ready_q <= bus.arvalid && !ready_q && !rvalid_q;
            // Response follows the accept by one cycle
            if (ready_q) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    assign bus.arready = ready_q;
    assign bus.rvalid  = rvalid_q;
    assign bus.rdata   = '0;
    assign bus.rresp   = axil_pkg::RESP_DECERR;

endmodule

// File: axil_decerr_wr.sv
module axil_decerr_wr (
    input  logic           aclk,
    input  logic           rst,
    axil_wr_if.subordinate bus
);

    logic ready_q;
    logic bvalid_q;

    // Single accept pulse, blocked while a response is pending
    always_ff @(posedge aclk) begin
        if (rst) begin
            ready_q  <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            ready_q <= bus.awvalid && bus.wvalid && !ready_q && !bvalid_q;
            if (ready_q) begin
                bvalid_q <= 1'b1;
            end else if (bvalid_q && bus.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign bus.awready = ready_q;
    assign bus.wready  = ready_q;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = axil_pkg::RESP_DECERR;

endmodule

// File: axil_interconnect.sv
module axil_interconnect #(
    parameter int NUMBER_SLAVE = 4,
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_OFFSET =
        axil_map_pkg::DEFAULT_OFFSET[NUMBER_SLAVE-1:0],
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_RANGE =
        axil_map_pkg::DEFAULT_RANGE[NUMBER_SLAVE-1:0]
) (
    input  logic                                           aclk,
    input  logic                                           rst,

    //////////////////////////////////////////////////////////////////////
    // Master side
    //////////////////////////////////////////////////////////////////////

    input  axil_pkg::addr_t                                m_axil_awaddr,
    input  logic                                           m_axil_awvalid,
    output logic                                           m_axil_awready,
    input  axil_pkg::data_t                                m_axil_wdata,
    input  logic [axil_pkg::AXI_STRB_WIDTH-1:0]            m_axil_wstrb,
    input  logic                                           m_axil_wvalid,
    output logic                                           m_axil_wready,
    output axil_pkg::resp_t                                m_axil_bresp,
    output logic                                           m_axil_bvalid,
    input  logic                                           m_axil_bready,

    input  axil_pkg::addr_t                                m_axil_araddr,
    input  logic                                           m_axil_arvalid,
    output logic                                           m_axil_arready,
    output axil_pkg::data_t                                m_axil_rdata,
    output axil_pkg::resp_t                                m_axil_rresp,
    output logic                                           m_axil_rvalid,
    input  logic                                           m_axil_rready,

    //////////////////////////////////////////////////////////////////////
    // Slave side, one entry per slave
    //////////////////////////////////////////////////////////////////////

    output axil_pkg::addr_t [NUMBER_SLAVE-1:0]             s_axil_awaddr,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_awvalid,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_awready,
    output axil_pkg::data_t [NUMBER_SLAVE-1:0]             s_axil_wdata,
    output logic [NUMBER_SLAVE-1:0][axil_pkg::AXI_STRB_WIDTH-1:0] s_axil_wstrb,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_wvalid,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_wready,
    input  axil_pkg::resp_t [NUMBER_SLAVE-1:0]             s_axil_bresp,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_bvalid,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_bready,

    output axil_pkg::addr_t [NUMBER_SLAVE-1:0]             s_axil_araddr,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_arvalid,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_arready,
    input  axil_pkg::data_t [NUMBER_SLAVE-1:0]             s_axil_rdata,
    input  axil_pkg::resp_t [NUMBER_SLAVE-1:0]             s_axil_rresp,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_rvalid,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_rready
);

    // Links to the unmapped-address responders
    axil_wr_if err_wr ();
    axil_rd_if err_rd ();

    axil_interconnect_wr #(
        .NUMBER_SLAVE    (NUMBER_SLAVE),
        .AXI_ADDR_OFFSET (AXI_ADDR_OFFSET),
        .AXI_ADDR_RANGE  (AXI_ADDR_RANGE)
    ) u_wr (
        .decerr (err_wr.manager),
        .*
    );

    axil_interconnect_rd #(
        .NUMBER_SLAVE    (NUMBER_SLAVE),
        .AXI_ADDR_OFFSET (AXI_ADDR_OFFSET),
        .AXI_ADDR_RANGE  (AXI_ADDR_RANGE)
    ) u_rd (
        .decerr (err_rd.manager),
        .*
    );

    axil_decerr_wr u_decerr_wr (
        .aclk (aclk),
        .rst  (rst),
        .bus  (err_wr.subordinate)
    );

    axil_decerr_rd u_decerr_rd (
        .aclk (aclk),
        .rst  (rst),
        .bus  (err_rd.subordinate)
    );

endmodule

// File: axil_interconnect_rd.sv
module axil_interconnect_rd #(
    parameter int NUMBER_SLAVE = 4,
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_OFFSET =
        axil_map_pkg::DEFAULT_OFFSET[NUMBER_SLAVE-1:0],
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_RANGE =
        axil_map_pkg::DEFAULT_RANGE[NUMBER_SLAVE-1:0]
) (
    input  logic                               aclk,
    input  logic                               rst,

    input  axil_pkg::addr_t                    m_axil_araddr,
    input  logic                               m_axil_arvalid,
    output logic                               m_axil_arready,
    output axil_pkg::data_t                    m_axil_rdata,
    output axil_pkg::resp_t                    m_axil_rresp,
    output logic                               m_axil_rvalid,
    input  logic                               m_axil_rready,

    output axil_pkg::addr_t [NUMBER_SLAVE-1:0] s_axil_araddr,
    output logic [NUMBER_SLAVE-1:0]            s_axil_arvalid,
    input  logic [NUMBER_SLAVE-1:0]            s_axil_arready,
    input  axil_pkg::data_t [NUMBER_SLAVE-1:0] s_axil_rdata,
    input  axil_pkg::resp_t [NUMBER_SLAVE-1:0] s_axil_rresp,
    input  logic [NUMBER_SLAVE-1:0]            s_axil_rvalid,
    output logic [NUMBER_SLAVE-1:0]            s_axil_rready,

    axil_rd_if.manager                         decerr
);

    typedef enum logic {IDLE, SEND} state_t;

    state_t                   state;
    logic                     ar_done;
    axil_map_pkg::slave_idx_t tgt, dec_idx;
    axil_pkg::addr_t          araddr_q;
    logic [NUMBER_SLAVE-1:0]  hit, is_tgt;
    logic                     is_decerr, accept, ar_fire, r_fire, rsp_phase;
    logic                     tgt_arready, tgt_rvalid;
    axil_pkg::data_t          tgt_rdata;
    axil_pkg::resp_t          tgt_rresp;

    //////////////////////////////////////////////////////////////////////
    // Window decode and per-slave routing
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUMBER_SLAVE; i++) begin : gen_port
        assign hit[i] = (m_axil_araddr >= AXI_ADDR_OFFSET[i]) &&
                        (m_axil_araddr - AXI_ADDR_OFFSET[i] < AXI_ADDR_RANGE[i]);
        assign is_tgt[i]         = (tgt == axil_map_pkg::slave_idx_t'(i));
        assign s_axil_araddr[i]  = araddr_q;
        assign s_axil_arvalid[i] = (state == SEND) && !ar_done && is_tgt[i];
        assign s_axil_rready[i]  = rsp_phase && m_axil_rready && is_tgt[i];
    end

    always_comb begin
        dec_idx = axil_map_pkg::NO_TARGET;
        for (int i = NUMBER_SLAVE - 1; i >= 0; i--) begin
            if (hit[i]) dec_idx = axil_map_pkg::slave_idx_t'(i);
        end
    end

    always_comb begin
        tgt_arready = decerr.arready;
        tgt_rvalid  = decerr.rvalid;
        tgt_rdata   = decerr.rdata;
        tgt_rresp   = decerr.rresp;
        for (int i = 0; i < NUMBER_SLAVE; i++) begin
            if (is_tgt[i]) begin
                tgt_arready = s_axil_arready[i];
                tgt_rvalid  = s_axil_rvalid[i];
                tgt_rdata   = s_axil_rdata[i];
                tgt_rresp   = s_axil_rresp[i];
            end
        end
    end

    assign is_decerr      = (tgt == axil_map_pkg::NO_TARGET);
    assign rsp_phase      = (state == SEND) && ar_done;
    assign decerr.araddr  = araddr_q;
    assign decerr.arvalid = (state == SEND) && !ar_done && is_decerr;
    assign decerr.rready  = rsp_phase && m_axil_rready && is_decerr;

    assign accept         = (state == IDLE) && m_axil_arvalid;
    assign m_axil_arready = accept;
    assign ar_fire        = (state == SEND) && !ar_done && tgt_arready;
    // r only passes once the address beat has gone out
    assign m_axil_rvalid  = rsp_phase && tgt_rvalid;
    assign m_axil_rdata   = tgt_rdata;
    assign m_axil_rresp   = tgt_rresp;
    assign r_fire         = m_axil_rvalid && m_axil_rready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            ar_done <= 1'b0;
            tgt     <= axil_map_pkg::NO_TARGET;
        end else if (state == IDLE) begin
            if (accept) begin
                state   <= SEND;
                ar_done <= 1'b0;
                tgt     <= dec_idx;
            end
        end else begin
            if (ar_fire) ar_done <= 1'b1;
            if (r_fire) state <= IDLE;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) araddr_q <= m_axil_araddr;
    end

endmodule

// File: axil_interconnect_wr.sv
module axil_interconnect_wr #(
    parameter int NUMBER_SLAVE = 4,
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_OFFSET =
        axil_map_pkg::DEFAULT_OFFSET[NUMBER_SLAVE-1:0],
    parameter axil_pkg::addr_t [NUMBER_SLAVE-1:0] AXI_ADDR_RANGE =
        axil_map_pkg::DEFAULT_RANGE[NUMBER_SLAVE-1:0]
) (
    input  logic                                           aclk,
    input  logic                                           rst,

    input  axil_pkg::addr_t                                m_axil_awaddr,
    input  logic                                           m_axil_awvalid,
    output logic                                           m_axil_awready,
    input  axil_pkg::data_t                                m_axil_wdata,
    input  logic [axil_pkg::AXI_STRB_WIDTH-1:0]            m_axil_wstrb,
    input  logic                                           m_axil_wvalid,
    output logic                                           m_axil_wready,
    output axil_pkg::resp_t                                m_axil_bresp,
    output logic                                           m_axil_bvalid,
    input  logic                                           m_axil_bready,

    output axil_pkg::addr_t [NUMBER_SLAVE-1:0]             s_axil_awaddr,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_awvalid,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_awready,
    output axil_pkg::data_t [NUMBER_SLAVE-1:0]             s_axil_wdata,
    output logic [NUMBER_SLAVE-1:0][axil_pkg::AXI_STRB_WIDTH-1:0] s_axil_wstrb,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_wvalid,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_wready,
    input  axil_pkg::resp_t [NUMBER_SLAVE-1:0]             s_axil_bresp,
    input  logic [NUMBER_SLAVE-1:0]                        s_axil_bvalid,
    output logic [NUMBER_SLAVE-1:0]                        s_axil_bready,

    axil_wr_if.manager                                     decerr
);

    typedef enum logic [1:0] {IDLE, SEND, RESP} state_t;

    state_t                              state;
    logic                                aw_done, w_done;
    axil_map_pkg::slave_idx_t            tgt, dec_idx;
    axil_pkg::addr_t                     awaddr_q;
    axil_pkg::data_t                     wdata_q;
    logic [axil_pkg::AXI_STRB_WIDTH-1:0] wstrb_q;
    logic [NUMBER_SLAVE-1:0]             hit, is_tgt;
    logic                                is_decerr, accept, aw_fire, w_fire, b_fire;
    logic                                tgt_awready, tgt_wready, tgt_bvalid;
    axil_pkg::resp_t                     tgt_bresp;

    //////////////////////////////////////////////////////////////////////
    // Window decode and per-slave routing
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUMBER_SLAVE; i++) begin : gen_port
        assign hit[i] = (m_axil_awaddr >= AXI_ADDR_OFFSET[i]) &&
                        (m_axil_awaddr - AXI_ADDR_OFFSET[i] < AXI_ADDR_RANGE[i]);
        assign is_tgt[i]         = (tgt == axil_map_pkg::slave_idx_t'(i));
        assign s_axil_awaddr[i]  = awaddr_q;
        assign s_axil_wdata[i]   = wdata_q;
        assign s_axil_wstrb[i]   = wstrb_q;
        assign s_axil_awvalid[i] = (state == SEND) && !aw_done && is_tgt[i];
        assign s_axil_wvalid[i]  = (state == SEND) && !w_done && is_tgt[i];
        assign s_axil_bready[i]  = (state == RESP) && m_axil_bready && is_tgt[i];
    end

    // Lowest matching window wins
    always_comb begin
        dec_idx = axil_map_pkg::NO_TARGET;
        for (int i = NUMBER_SLAVE - 1; i >= 0; i--) begin
            if (hit[i]) dec_idx = axil_map_pkg::slave_idx_t'(i);
        end
    end

    // Return path from the latched target
    always_comb begin
        tgt_awready = decerr.awready;
        tgt_wready  = decerr.wready;
        tgt_bvalid  = decerr.bvalid;
        tgt_bresp   = decerr.bresp;
        for (int i = 0; i < NUMBER_SLAVE; i++) begin
            if (is_tgt[i]) begin
                tgt_awready = s_axil_awready[i];
                tgt_wready  = s_axil_wready[i];
                tgt_bvalid  = s_axil_bvalid[i];
                tgt_bresp   = s_axil_bresp[i];
            end
        end
    end

    assign is_decerr      = (tgt == axil_map_pkg::NO_TARGET);
    assign decerr.awaddr  = awaddr_q;
    assign decerr.wdata   = wdata_q;
    assign decerr.wstrb   = wstrb_q;
    assign decerr.awvalid = (state == SEND) && !aw_done && is_decerr;
    assign decerr.wvalid  = (state == SEND) && !w_done && is_decerr;
    assign decerr.bready  = (state == RESP) && m_axil_bready && is_decerr;

    // Both beats taken together from the master
    assign accept         = (state == IDLE) && m_axil_awvalid && m_axil_wvalid;
    assign m_axil_awready = accept;
    assign m_axil_wready  = accept;
    assign aw_fire        = (state == SEND) && !aw_done && tgt_awready;
    assign w_fire         = (state == SEND) && !w_done && tgt_wready;
    assign m_axil_bvalid  = (state == RESP) && tgt_bvalid;
    assign m_axil_bresp   = tgt_bresp;
    assign b_fire         = m_axil_bvalid && m_axil_bready;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            tgt     <= axil_map_pkg::NO_TARGET;
        end else begin
            case (state)
                IDLE: if (accept) begin
                    state   <= SEND;
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    tgt     <= dec_idx;
                end
                SEND: begin
                    if (aw_fire) aw_done <= 1'b1;
                    if (w_fire) w_done <= 1'b1;
                    if ((aw_done || aw_fire) && (w_done || w_fire)) state <= RESP;
                end
                RESP: if (b_fire) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            awaddr_q <= m_axil_awaddr;
            wdata_q  <= m_axil_wdata;
            wstrb_q  <= m_axil_wstrb;
        end
    end

endmodule

// File: axil_map_pkg.sv
package axil_map_pkg;

    localparam int MAX_SLAVES = 16;

    // Target index, one past the last slave means the DECERR responder
    typedef logic [4:0] slave_idx_t;
    localparam slave_idx_t NO_TARGET = 5'd16;

    typedef axil_pkg::addr_t [MAX_SLAVES-1:0] addr_tab_t;

    localparam axil_pkg::addr_t MAP_BASE   = 32'h4000_0000;
    localparam axil_pkg::addr_t MAP_STRIDE = 32'h0000_1000;

    // Slave windows packed back to back from MAP_BASE
    function automatic addr_tab_t default_offsets();
        addr_tab_t tab;
        for (int i = 0; i < MAX_SLAVES; i++) begin
            tab[i] = MAP_BASE + axil_pkg::addr_t'(i) * MAP_STRIDE;
        end
        return tab;
    endfunction

    localparam addr_tab_t DEFAULT_OFFSET = default_offsets();
    localparam addr_tab_t DEFAULT_RANGE  = {MAX_SLAVES{MAP_STRIDE}};

endpackage

// File: axil_pkg.sv
package axil_pkg;

    // Bus widths, fixed for this interconnect
    localparam int AXI_DATA_WIDTH = 32;
    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_STRB_WIDTH = AXI_DATA_WIDTH / 8;

    typedef logic [AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [1:0]                resp_t;

    // AXI response encodings
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

endpackage

// File: axil_rd_if.sv
interface axil_rd_if;

    axil_pkg::addr_t araddr;
    logic            arvalid;
    logic            arready;

    axil_pkg::data_t rdata;
    axil_pkg::resp_t rresp;
    logic            rvalid;
    logic            rready;

    modport manager (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport subordinate (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

// File: axil_wr_if.sv
interface axil_wr_if;

    axil_pkg::addr_t                    awaddr;
    logic                               awvalid;
    logic                               awready;

    axil_pkg::data_t                    wdata;
    logic [axil_pkg::AXI_STRB_WIDTH-1:0] wstrb;
    logic                               wvalid;
    logic                               wready;

    axil_pkg::resp_t                    bresp;
    logic                               bvalid;
    logic                               bready;

    modport manager (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );

    modport subordinate (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bresp, bvalid
    );

endinterface

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_axil_interconnect \
    -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 ; cat sim.log
grep -q "ALL TESTS PASSED" sim.log && exit 0 || exit 1

// File: tb_axil_interconnect.sv
module tb_axil_interconnect;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NS = 4;
    localparam int N_TRANS = 60;
    localparam axil_pkg::addr_t WIN_BASE = 32'h4000_0000;
    localparam axil_pkg::addr_t WIN_SIZE = 32'h0000_1000;

    logic aclk = 1'b0;
    logic rst = 1'b1;
    axil_pkg::addr_t m_axil_awaddr = '0, m_axil_araddr = '0;
    axil_pkg::data_t m_axil_wdata = '0, m_axil_rdata;
    logic [3:0] m_axil_wstrb = '0;
    axil_pkg::resp_t m_axil_bresp, m_axil_rresp;
    logic m_axil_awvalid = 1'b0, m_axil_wvalid = 1'b0, m_axil_arvalid = 1'b0;
    logic m_axil_bready = 1'b0, m_axil_rready = 1'b0;
    logic m_axil_awready, m_axil_wready, m_axil_bvalid, m_axil_arready, m_axil_rvalid;
    axil_pkg::addr_t [NS-1:0] s_axil_awaddr, s_axil_araddr;
    axil_pkg::data_t [NS-1:0] s_axil_wdata, s_axil_rdata;
    logic [NS-1:0][3:0] s_axil_wstrb;
    axil_pkg::resp_t [NS-1:0] s_axil_bresp, s_axil_rresp;
    logic [NS-1:0] s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic [NS-1:0] s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic [NS-1:0] s_axil_rvalid, s_axil_rready;

    // Scoreboard mirrors the 16-word memory of each slave model
    axil_pkg::data_t sb [NS][16];
    axil_pkg::resp_t exp_bresp [$];
    axil_pkg::resp_t exp_rresp [$];
    axil_pkg::data_t exp_rdata [$];
    logic [31:0] ready_rng = 32'hbc4e;
    logic [31:0] stim_rng = 32'hbc4e;
    int bp_max = 0;
    logic rst_d = 1'b0, b_held = 1'b0, r_held = 1'b0;
    axil_pkg::resp_t b_prev, r_prev_resp;
    axil_pkg::data_t r_prev_data;

    axil_interconnect #(.NUMBER_SLAVE(NS)) u_axil_interconnect (.*);

    always #4 aclk = ~aclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    // Lowest window holding the address, NO_TARGET if none
    function automatic axil_map_pkg::slave_idx_t decode_ref(input axil_pkg::addr_t addr);
        axil_map_pkg::slave_idx_t idx;
        axil_pkg::addr_t base;
        idx = axil_map_pkg::NO_TARGET;
        for (int i = NS - 1; i >= 0; i--) begin
            base = WIN_BASE + WIN_SIZE * i;
            if (addr >= base && addr - base < WIN_SIZE) idx = axil_map_pkg::slave_idx_t'(i);
        end
        return idx;
    endfunction

    // Edges of slave s: offset, last byte, one past the end
    function automatic axil_pkg::addr_t edge_addr(input int s, input int e);
        return WIN_BASE + WIN_SIZE * s + ((e == 0) ? 32'h0 : WIN_SIZE - 2 + e);
    endfunction

    // Byte-wise merge into the scoreboard, gives the expected bresp
    function automatic axil_pkg::resp_t predict_write(input axil_pkg::addr_t addr,
            input axil_pkg::data_t data, input logic [3:0] strb);
        axil_map_pkg::slave_idx_t idx;
        idx = decode_ref(addr);
        if (idx == axil_map_pkg::NO_TARGET) return axil_pkg::RESP_DECERR;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) sb[idx[1:0]][addr[5:2]][8*b +: 8] = data[8*b +: 8];
        end
        return (idx == 3) ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic do_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
            input logic [3:0] strb);
        logic aw_open, w_open;
        exp_bresp.push_back(predict_write(addr, data, strb));
        m_axil_awaddr  <= addr;
        m_axil_wdata   <= data;
        m_axil_wstrb   <= strb;
        m_axil_awvalid <= 1'b1;
        m_axil_wvalid  <= 1'b1;
        aw_open = 1'b1;
        w_open  = 1'b1;
        // Each channel closes on its own ready
        while (aw_open || w_open) begin
            @(posedge aclk);
            if (aw_open && m_axil_awready) begin
                aw_open = 1'b0;
                m_axil_awvalid <= 1'b0;
            end
            if (w_open && m_axil_wready) begin
                w_open = 1'b0;
                m_axil_wvalid <= 1'b0;
            end
        end
        do @(posedge aclk); while (!m_axil_bvalid);
        repeat (next_rand() % (bp_max + 1)) @(posedge aclk);
        m_axil_bready <= 1'b1;
        do @(posedge aclk); while (!m_axil_bvalid);
        m_axil_bready <= 1'b0;
    endtask

    task automatic do_read(input axil_pkg::addr_t addr);
        axil_map_pkg::slave_idx_t idx;
        idx = decode_ref(addr);
        if (idx == axil_map_pkg::NO_TARGET) begin
            exp_rdata.push_back('0);
            exp_rresp.push_back(axil_pkg::RESP_DECERR);
        end else begin
            exp_rdata.push_back(sb[idx[1:0]][addr[5:2]]);
            exp_rresp.push_back((idx == 3) ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY);
        end
        m_axil_araddr  <= addr;
        m_axil_arvalid <= 1'b1;
        do @(posedge aclk); while (!m_axil_arready);
        m_axil_arvalid <= 1'b0;
        do @(posedge aclk); while (!m_axil_rvalid);
        repeat (next_rand() % (bp_max + 1)) @(posedge aclk);
        m_axil_rready <= 1'b1;
        do @(posedge aclk); while (!m_axil_rvalid);
        m_axil_rready <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Slave models with random back-pressure
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        ready_rng <= rst ? 32'hbc4e : xorshift32(ready_rng);
    end

    for (genvar i = 0; i < NS; i++) begin : gen_slave
        axil_pkg::data_t mem [16];
        axil_pkg::addr_t awaddr_q;
        axil_pkg::data_t wdata_q;
        axil_pkg::data_t rdata_q = '0;
        logic [3:0] wstrb_q;
        logic aw_got, w_got;
        logic awready_q = 1'b0, wready_q = 1'b0, bvalid_q = 1'b0;
        logic arready_q = 1'b0, rvalid_q = 1'b0;
        logic aw_hs, w_hs, ar_hs;

        assign aw_hs = s_axil_awvalid[i] && awready_q;
        assign w_hs  = s_axil_wvalid[i] && wready_q;
        assign ar_hs = s_axil_arvalid[i] && arready_q;
        assign s_axil_awready[i] = awready_q;
        assign s_axil_wready[i]  = wready_q;
        assign s_axil_bvalid[i]  = bvalid_q;
        // Slave 3 flags every access as a slave error
        assign s_axil_bresp[i]   = (i == 3) ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
        assign s_axil_arready[i] = arready_q;
        assign s_axil_rvalid[i]  = rvalid_q;
        assign s_axil_rdata[i]   = rdata_q;
        assign s_axil_rresp[i]   = s_axil_bresp[i];

        always @(posedge aclk) begin
            if (rst) begin
                {aw_got, w_got, awready_q, wready_q} <= '0;
                {bvalid_q, arready_q, rvalid_q} <= '0;
                rdata_q <= '0;
                for (int k = 0; k < 16; k++) mem[k] <= '0;
            end else begin
                awready_q <= ready_rng[i] && !aw_got && !aw_hs && !bvalid_q;
                wready_q  <= ready_rng[i + 8] && !w_got && !w_hs && !bvalid_q;
                arready_q <= ready_rng[i + 16] && !ar_hs && !rvalid_q;
                if (aw_hs) begin
                    aw_got   <= 1'b1;
                    awaddr_q <= s_axil_awaddr[i];
                end
                if (w_hs) begin
                    w_got   <= 1'b1;
                    wdata_q <= s_axil_wdata[i];
                    wstrb_q <= s_axil_wstrb[i];
                end
                // Commit once both beats are in
                if (aw_got && w_got) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb_q[b]) mem[awaddr_q[5:2]][8*b +: 8] <= wdata_q[8*b +: 8];
                    end
                    {aw_got, w_got, bvalid_q} <= 3'b001;
                end else if (bvalid_q && s_axil_bready[i]) begin
                    bvalid_q <= 1'b0;
                end
                if (ar_hs) begin
                    rvalid_q <= 1'b1;
                    rdata_q  <= mem[s_axil_araddr[i][5:2]];
                end else if (rvalid_q && s_axil_rready[i]) begin
                    rvalid_q <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checker at the master ports
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (rst_d) begin
            expect_eq("m_axil_awready", 32'(m_axil_awready), 0);
            expect_eq("m_axil_wready", 32'(m_axil_wready), 0);
            expect_eq("m_axil_arready", 32'(m_axil_arready), 0);
            expect_eq("m_axil_bvalid", 32'(m_axil_bvalid), 0);
            expect_eq("m_axil_rvalid", 32'(m_axil_rvalid), 0);
            expect_eq("s_axil_awvalid", 32'(s_axil_awvalid), 0);
            expect_eq("s_axil_wvalid", 32'(s_axil_wvalid), 0);
            expect_eq("s_axil_arvalid", 32'(s_axil_arvalid), 0);
        end
        // Stalled responses must hold still
        if (b_held) begin
            expect_eq("m_axil_bvalid", 32'(m_axil_bvalid), 1);
            expect_eq("m_axil_bresp", 32'(m_axil_bresp), 32'(b_prev));
        end
        if (r_held) begin
            expect_eq("m_axil_rvalid", 32'(m_axil_rvalid), 1);
            expect_eq("m_axil_rresp", 32'(m_axil_rresp), 32'(r_prev_resp));
            expect_eq("m_axil_rdata", m_axil_rdata, r_prev_data);
        end
        if (m_axil_bvalid && m_axil_bready) begin
            assert (exp_bresp.size() > 0) else stop_run("Write response came with none pending");
            expect_eq("m_axil_bresp", 32'(m_axil_bresp), 32'(exp_bresp.pop_front()));
        end
        if (m_axil_rvalid && m_axil_rready) begin
            assert (exp_rresp.size() > 0) else stop_run("Read response came with none pending");
            expect_eq("m_axil_rresp", 32'(m_axil_rresp), 32'(exp_rresp.pop_front()));
            expect_eq("m_axil_rdata", m_axil_rdata, exp_rdata.pop_front());
        end
        rst_d       <= rst;
        b_held      <= m_axil_bvalid && !m_axil_bready;
        b_prev      <= m_axil_bresp;
        r_held      <= m_axil_rvalid && !m_axil_rready;
        r_prev_resp <= m_axil_rresp;
        r_prev_data <= m_axil_rdata;
    end

    initial begin
        repeat (200 * N_TRANS + 10) @(posedge aclk);
        stop_run("Timeout: the transactions did not finish within the cycle budget");
    end

    initial begin
        axil_pkg::addr_t addr;
        sb = '{default: '0};
        repeat (3) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);

        // Full word to each slave, then all read back
        for (int s = 0; s < NS; s++) begin
            do_write(WIN_BASE + WIN_SIZE * s + 32'h10, next_rand(), 4'hf);
        end
        for (int s = 0; s < NS; s++) begin
            do_read(WIN_BASE + WIN_SIZE * s + 32'h10);
        end
        // Partial strobes
        for (int n = 0; n < 8; n++) begin
            addr = WIN_BASE + WIN_SIZE * (n % NS) + 32'h10;
            do_write(addr, next_rand(), 4'(next_rand()));
            do_read(addr);
        end
        // Unmapped, then slave 0 word at the same index
        do_write(32'h3fff_f010, next_rand(), 4'hf);
        do_read(32'h3fff_f010);
        do_read(32'h4000_4000);
        do_read(WIN_BASE + 32'h10);
        // Window edges, every edge written before any is read
        for (int s = 0; s < NS; s++) begin
            for (int e = 0; e < 3; e++) begin
                do_write(edge_addr(s, e), next_rand(), 4'hf);
            end
        end
        for (int s = 0; s < NS; s++) begin
            for (int e = 0; e < 3; e++) begin
                do_read(edge_addr(s, e));
            end
        end
        // Write and read together under back-pressure
        bp_max = 6;
        for (int s = 0; s < NS; s++) begin
            addr = WIN_BASE + WIN_SIZE * s + 32'h20;
            fork
                do_write(addr, next_rand(), 4'hf);
                do_read(WIN_BASE + WIN_SIZE * ((s + 1) % NS) + 32'h20);
            join
        end

        repeat (2) @(posedge aclk);
        assert (exp_bresp.size() == 0 && exp_rresp.size() == 0)
            else stop_run("Some expected responses never arrived");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
axil_pkg.sv
axil_map_pkg.sv
axil_wr_if.sv
axil_rd_if.sv
axil_decerr_wr.sv
axil_decerr_rd.sv
axil_interconnect_wr.sv
axil_interconnect_rd.sv
axil_interconnect.sv
tb_axil_interconnect.sv
